/* dv/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb;
	import ooo_pkg::*;

	//////////////////////////////////////////////////
	// run limits
	//////////////////////////////////////////////////

	localparam int max_commits = 400;
	// worst case per commit, with bus waits and back-pressure
	localparam int cycle_limit = max_commits * 20;
	localparam int mem_words = 64;
	// x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;

	logic clock;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [xlen-1:0] wb_adr;
	logic [xlen-1:0] wb_dat_i;
	logic wb_ack;
	commit_t commit;

	logic [31:0] lfsr_state;
	logic [31:0] mem [mem_words];
	logic [31:0] model_regs [num_arch_regs];
	logic [31:0] model_pc;
	// next address the core should request
	logic [31:0] fetch_pc;
	logic [31:0] req_adr;
	logic req_active;
	int wait_left;
	int errors;
	int commits;
	int cycles;
	logic timed_out;

	ooo_core u_ooo_core (
		.clock(clock),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.commit(commit)
	);

	// 4 ns period
	always #2 clock = ~clock;

	//////////////////////////////////////////////////
	// stimulus source
	//////////////////////////////////////////////////

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] bits;
		bits = '0;
		for (int k = 0; k < n; k++) begin
			bits = {bits[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ lfsr_taps;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return bits;
	endfunction

	// mostly alu words on x0..x7, about one in eight something else
	function automatic logic [31:0] make_word();
		logic [6:0] other_ops [8];
		logic [24:0] upper;
		logic [6:0] other;
		logic [11:0] imm;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic alt;
		logic [31:0] w;
		// lui auipc jal jalr branch load store system
		other_ops = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
			7'b1100011, 7'b0000011, 7'b0100011, 7'b1110011};
		if (take_bits(3) == 32'd0) begin
			upper = 25'(take_bits(25));
			other = other_ops[take_bits(3)];
			w = {upper, other};
		end else begin
			rd = 5'(take_bits(3));
			rs1 = 5'(take_bits(3));
			rs2 = 5'(take_bits(3));
			funct3 = 3'(take_bits(3));
			alt = 1'(take_bits(1));
			if (take_bits(1) != 32'd0) begin
				// r-type, funct7 bit 5 only for sub and sra
				if (funct3 != 3'b000 && funct3 != 3'b101)
					alt = 1'b0;
				w = {1'b0, alt, 5'b0, rs2, rs1, funct3, rd, opcode_op};
			end else if (funct3 == 3'b001 || funct3 == 3'b101) begin
				// slli, srli, srai with shamt in imm[4:0]
				if (funct3 == 3'b001)
					alt = 1'b0;
				w = {1'b0, alt, 5'b0, rs2, rs1, funct3, rd, opcode_op_imm};
			end else begin
				imm = 12'(take_bits(12));
				w = {imm, rs1, funct3, rd, opcode_op_imm};
			end
		end
		return w;
	endfunction

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// rv32i semantics on the model's register file
	function automatic logic [31:0] model_exec(inst_t w);
		logic [31:0] a;
		logic [31:0] b;
		logic is_op;
		logic alt;
		logic [31:0] res;
		is_op = (w.r.opcode == opcode_op);
		a = model_regs[w.r.rs1];
		if (is_op) begin
			b = model_regs[w.r.rs2];
			alt = w.r.funct7[5];
		end else begin
			b = {{20{w.i.imm[11]}}, w.i.imm};
			alt = w.i.imm[10];
		end
		case (w.r.funct3)
			3'b000: res = (is_op && alt) ? a - b : a + b;
			3'b001: res = a << b[4:0];
			3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: res = (a < b) ? 32'd1 : 32'd0;
			3'b100: res = a ^ b;
			3'b101: res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: res = a | b;
			default: res = a & b;
		endcase
		return res;
	endfunction

	task automatic report_mismatch(string test, logic [31:0] expected, logic [31:0] actual);
		$display("[FAIL] %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
		errors++;
	endtask

	task automatic report_problem(string what);
		$display("error at cycle %0d: %s", cycles, what);
		errors++;
	endtask

	//////////////////////////////////////////////////
	// wishbone slave with random waits
	//////////////////////////////////////////////////

	task automatic bus_step();
		assert (wb_cyc == wb_stb)
			else report_problem("cyc and stb differ");
		assert (!wb_we)
			else report_problem("write enable raised on an instruction fetch");
		if (wb_ack) begin
			// ack was taken at this edge, bus must be idle now
			wb_ack = 1'b0;
			req_active = 1'b0;
			assert (!wb_cyc)
				else report_problem("cyc still high in the cycle after ack");
		end else if (wb_cyc) begin
			if (!req_active) begin
				req_active = 1'b1;
				req_adr = wb_adr;
				wait_left = int'(take_bits(2));
				assert (wb_adr == fetch_pc)
					else report_mismatch("wb_adr", fetch_pc, wb_adr);
				fetch_pc = fetch_pc + 32'd4;
			end else begin
				assert (wb_adr == req_adr)
					else report_mismatch("wb_adr_stable", req_adr, wb_adr);
			end
			if (wait_left == 0) begin
				wb_ack = 1'b1;
				wb_dat_i = mem[wb_adr[7:2]];
			end else begin
				wait_left--;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// commit checks
	//////////////////////////////////////////////////

	task automatic commit_step();
		inst_t w;
		logic is_alu;
		logic exp_wr;
		logic [31:0] exp_data;
		string test;
		if (commit.valid) begin
			w = mem[model_pc[7:2]];
			is_alu = (w.r.opcode == opcode_op) || (w.r.opcode == opcode_op_imm);
			// x0 and non-alu words leave the registers alone
			exp_wr = is_alu && (w.r.rd != 5'd0);
			exp_data = model_exec(w);
			if (w.r.opcode == opcode_op)
				test = "op";
			else if (w.r.opcode == opcode_op_imm)
				test = "op_imm";
			else
				test = "other";
			assert (commit.pc == model_pc)
				else report_mismatch("commit_pc", model_pc, commit.pc);
			assert (commit.wr_en == exp_wr)
				else report_mismatch({test, "_wr_en"}, 32'(exp_wr), 32'(commit.wr_en));
			if (exp_wr) begin
				assert (commit.rd == w.r.rd)
					else report_mismatch({test, "_rd"}, 32'(w.r.rd), 32'(commit.rd));
				assert (commit.data == exp_data)
					else report_mismatch({test, "_result"}, exp_data, commit.data);
				model_regs[w.r.rd] = exp_data;
			end
			model_pc = model_pc + 32'd4;
			commits++;
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		lfsr_state = 32'd97;
		model_pc = '0;
		fetch_pc = '0;
		req_adr = '0;
		req_active = 1'b0;
		wait_left = 0;
		errors = 0;
		commits = 0;
		cycles = 0;
		timed_out = 1'b0;
		for (int i = 0; i < num_arch_regs; i++)
			model_regs[i] = '0;
		for (int i = 0; i < mem_words; i++)
			mem[i] = make_word();

		repeat (10) @(posedge clock);
		#1 reset = 1'b0;

		// sample and drive 1 ns after each rising edge
		while (commits < max_commits && !timed_out) begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles >= cycle_limit) begin
				timed_out = 1'b1;
				$display("timeout: %0d of %0d commits seen after %0d cycles",
					commits, max_commits, cycles);
			end else begin
				bus_step();
				commit_step();
			end
		end

		$display("summary: %0d errors, %0d commits, %0d cycles", errors, commits, cycles);
		if (errors == 0 && !timed_out)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  ooo_pkg::issue_packet_t  exec,
	output ooo_pkg::cdb_t           cdb
);
	import ooo_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] result;
	logic [4:0] shamt;

	assign op_a = exec.src1.value;
	assign op_b = exec.src2.value;
	// shifts only look at the low five bits
	assign shamt = op_b[4:0];

	always_comb begin
		case (exec.alu_op)
			alu_add:  result = op_a + op_b;
			alu_sub:  result = op_a - op_b;
			alu_sll:  result = op_a << shamt;
			alu_slt:  result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
			alu_xor:  result = op_a ^ op_b;
			alu_srl:  result = op_a >> shamt;
			alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
			alu_or:   result = op_a | op_b;
			alu_and:  result = op_a & op_b;
			default:  result = '0;
		endcase
	end

	// one-stage pipe, result register is the cdb
	always_ff @(posedge clock) begin
		if (reset)
			cdb.valid <= 1'b0;
		else
			cdb.valid <= exec.valid;
		cdb.tag <= exec.dest;
		cdb.value <= result;
	end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
	input  logic                      clock,
	input  logic                      reset,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output logic [ooo_pkg::xlen-1:0]  wb_adr,
	input  logic [ooo_pkg::xlen-1:0]  wb_dat_i,
	input  logic                      wb_ack,
	input  logic                      fetch_take,
	output ooo_pkg::fetch_t           fetch
);
	import ooo_pkg::*;

	logic [xlen-1:0] pc;

	// read-only master, stb follows cyc
	assign wb_stb = wb_cyc;
	assign wb_we = 1'b0;
	// pc only moves on ack, so the address holds for the whole request
	assign wb_adr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_cyc <= 1'b0;
			pc <= '0;
			fetch.valid <= 1'b0;
		end else begin
			if (fetch_take)
				fetch.valid <= 1'b0;
			if (wb_cyc && wb_ack) begin
				// word lands in the buffer, bus drops for one cycle at least
				wb_cyc <= 1'b0;
				fetch.valid <= 1'b1;
				fetch.pc <= pc;
				fetch.inst <= wb_dat_i;
				pc <= pc + xlen'(4);
			end else if (!wb_cyc && (!fetch.valid || fetch_take)) begin
				// next request only once the buffer frees up
				wb_cyc <= 1'b1;
			end
		end
	end

	// request held with a steady address until acked
	assert property (@(posedge clock) disable iff (reset)
		wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr));

	// one idle cycle after every ack
	assert property (@(posedge clock) disable iff (reset)
		wb_stb && wb_ack |=> !wb_cyc && !wb_stb);

endmodule

/* hw/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
	input  logic                      clock,
	input  logic                      reset,
	input  ooo_pkg::fetch_t           fetch,
	output logic                      fetch_take,
	input  logic                      rob_full,
	input  logic                      rs_full,
	input  ooo_pkg::rob_tag_t         alloc_tag,
	input  ooo_pkg::operand_t         map_rs1,
	input  ooo_pkg::operand_t         map_rs2,
	output ooo_pkg::reg_idx_t         lookup_rs1,
	output ooo_pkg::reg_idx_t         lookup_rs2,
	input  ooo_pkg::operand_t         read_op1,
	input  ooo_pkg::operand_t         read_op2,
	output logic                      alloc_en,
	output ooo_pkg::reg_idx_t         alloc_rd,
	output logic                      alloc_wr_en,
	output logic                      alloc_done,
	output logic [ooo_pkg::xlen-1:0]  alloc_pc,
	output logic                      rename_en,
	output ooo_pkg::reg_idx_t         rename_rd,
	output ooo_pkg::rob_tag_t         rename_tag,
	output ooo_pkg::issue_packet_t    issue,
	input  ooo_pkg::commit_t          commit
);
	import ooo_pkg::*;

	inst_t word;
	logic is_op;
	logic is_op_imm;
	logic is_alu;
	logic can_issue;
	alu_op_t alu_op;
	logic [xlen-1:0] imm_value;
	logic [xlen-1:0] regs [num_arch_regs];

	// rf, then ready rob value, else wait on the tag
	function automatic operand_t resolve(operand_t map_op, operand_t rob_op,
			logic [xlen-1:0] rf_value);
		operand_t res;
		if (map_op.ready)
			res = '{ready: 1'b1, tag: '0, value: rf_value};
		else if (rob_op.ready)
			res = '{ready: 1'b1, tag: '0, value: rob_op.value};
		else
			res = '{ready: 1'b0, tag: map_op.tag, value: '0};
		return res;
	endfunction

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	assign word = fetch.inst;
	assign is_op = (word.r.opcode == opcode_op);
	assign is_op_imm = (word.i.opcode == opcode_op_imm);
	assign is_alu = is_op || is_op_imm;
	assign imm_value = {{(xlen-12){word.i.imm[11]}}, word.i.imm};

	always_comb begin
		case (word.r.funct3)
			3'b000: alu_op = (is_op && word.r.funct7[5]) ? alu_sub : alu_add;
			3'b001: alu_op = alu_sll;
			3'b010: alu_op = alu_slt;
			3'b011: alu_op = alu_sltu;
			3'b100: alu_op = alu_xor;
			// sra and srai share bit 30 as the arithmetic flag
			3'b101: alu_op = word.r.funct7[5] ? alu_sra : alu_srl;
			3'b110: alu_op = alu_or;
			default: alu_op = alu_and;
		endcase
	end

	//////////////////////////////////////////////////
	// issue and rob allocation
	//////////////////////////////////////////////////

	// station space only matters for alu words
	assign can_issue = fetch.valid && !rob_full && (!is_alu || !rs_full);
	assign fetch_take = can_issue;

	assign lookup_rs1 = word.r.rs1;
	assign lookup_rs2 = word.r.rs2;

	assign alloc_en = can_issue;
	assign alloc_rd = word.r.rd;
	// x0 and other opcodes never write
	assign alloc_wr_en = is_alu && (word.r.rd != '0);
	assign alloc_done = !is_alu;
	assign alloc_pc = fetch.pc;

	assign rename_en = can_issue && alloc_wr_en;
	assign rename_rd = word.r.rd;
	assign rename_tag = alloc_tag;

	always_comb begin
		issue.valid = can_issue && is_alu;
		issue.alu_op = alu_op;
		issue.src1 = resolve(map_rs1, read_op1, regs[word.r.rs1]);
		issue.src2 = is_op_imm ? '{ready: 1'b1, tag: '0, value: imm_value}
			: resolve(map_rs2, read_op2, regs[word.r.rs2]);
		issue.dest = alloc_tag;
	end

	// architectural registers, written at commit
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_arch_regs; i++)
				regs[i] <= '0;
		end else if (commit.valid && commit.wr_en && commit.rd != '0) begin
			regs[commit.rd] <= commit.data;
		end
	end

endmodule

/* hw/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core (
	input  logic                      clock,
	input  logic                      reset,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output logic [ooo_pkg::xlen-1:0]  wb_adr,
	input  logic [ooo_pkg::xlen-1:0]  wb_dat_i,
	input  logic                      wb_ack,
	output ooo_pkg::commit_t          commit
);
	import ooo_pkg::*;

	//////////////////////////////////////////////////
	// interconnect
	//////////////////////////////////////////////////

	fetch_t fetch;
	logic fetch_take;
	// rename lookups and rob read-out
	reg_idx_t lookup_rs1;
	reg_idx_t lookup_rs2;
	operand_t map_rs1;
	operand_t map_rs2;
	operand_t read_op1;
	operand_t read_op2;
	// rob allocation
	logic alloc_en;
	reg_idx_t alloc_rd;
	logic alloc_wr_en;
	logic alloc_done;
	logic [xlen-1:0] alloc_pc;
	rob_tag_t alloc_tag;
	logic rob_full;
	logic rs_full;
	logic rename_en;
	reg_idx_t rename_rd;
	rob_tag_t rename_tag;
	// execute path
	issue_packet_t issue;
	issue_packet_t exec;
	cdb_t cdb;

	fetch_unit u_fetch_unit (
		.clock(clock), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
		.fetch_take(fetch_take), .fetch(fetch)
	);

	issue_stage u_issue_stage (
		.clock(clock), .reset(reset),
		.fetch(fetch), .fetch_take(fetch_take),
		.rob_full(rob_full), .rs_full(rs_full), .alloc_tag(alloc_tag),
		.map_rs1(map_rs1), .map_rs2(map_rs2),
		.lookup_rs1(lookup_rs1), .lookup_rs2(lookup_rs2),
		.read_op1(read_op1), .read_op2(read_op2),
		.alloc_en(alloc_en), .alloc_rd(alloc_rd), .alloc_wr_en(alloc_wr_en),
		.alloc_done(alloc_done), .alloc_pc(alloc_pc),
		.rename_en(rename_en), .rename_rd(rename_rd), .rename_tag(rename_tag),
		.issue(issue), .commit(commit)
	);

	rename_map u_rename_map (
		.clock(clock), .reset(reset),
		.lookup_rs1(lookup_rs1), .lookup_rs2(lookup_rs2),
		.map_rs1(map_rs1), .map_rs2(map_rs2),
		.rename_en(rename_en), .rename_rd(rename_rd), .rename_tag(rename_tag),
		.commit(commit)
	);

	// rob reads the slots the map points at
	reorder_buffer u_reorder_buffer (
		.clock(clock), .reset(reset),
		.alloc_en(alloc_en), .alloc_rd(alloc_rd), .alloc_wr_en(alloc_wr_en),
		.alloc_done(alloc_done), .alloc_pc(alloc_pc),
		.alloc_tag(alloc_tag), .rob_full(rob_full),
		.read_tag1(map_rs1.tag), .read_tag2(map_rs2.tag),
		.read_op1(read_op1), .read_op2(read_op2),
		.cdb(cdb), .commit(commit)
	);

	reservation_station u_reservation_station (
		.clock(clock), .reset(reset),
		.issue(issue), .cdb(cdb), .rs_full(rs_full), .exec(exec)
	);

	alu_unit u_alu_unit (
		.clock(clock), .reset(reset),
		.exec(exec), .cdb(cdb)
	);

endmodule

/* hw/ooo_pkg.sv */
package ooo_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	localparam int xlen = 32;
	localparam int num_arch_regs = 32;
	localparam int rob_depth = 8;
	localparam int rs_depth = 4;

	// rv32i major opcodes that execute
	localparam logic [6:0] opcode_op = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;

	typedef logic [4:0] reg_idx_t;
	typedef logic [$clog2(rob_depth)-1:0] rob_tag_t;

	// one fetched word, seen as r-type or i-type
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_idx_t   rs2;
			reg_idx_t   rs1;
			logic [2:0] funct3;
			reg_idx_t   rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			reg_idx_t    rs1;
			logic [2:0]  funct3;
			reg_idx_t    rd;
			logic [6:0]  opcode;
		} i;
	} inst_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_op_t;

	//////////////////////////////////////////////////
	// pipeline structs
	//////////////////////////////////////////////////

	// known value, or waiting on a rob tag
	typedef struct packed {
		logic             ready;
		rob_tag_t         tag;
		logic [xlen-1:0]  value;
	} operand_t;

	typedef struct packed {
		logic     valid;
		alu_op_t  alu_op;
		operand_t src1;
		operand_t src2;
		rob_tag_t dest;
	} issue_packet_t;

	typedef struct packed {
		logic            valid;
		rob_tag_t        tag;
		logic [xlen-1:0] value;
	} cdb_t;

	typedef struct packed {
		logic            valid;
		logic            wr_en;
		reg_idx_t        rd;
		logic [xlen-1:0] data;
		logic [xlen-1:0] pc;
	} commit_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		inst_t           inst;
	} fetch_t;

endpackage

/* hw/rename_map.sv */
`timescale 1ns/1ps

module rename_map (
	input  logic                clock,
	input  logic                reset,
	input  ooo_pkg::reg_idx_t   lookup_rs1,
	input  ooo_pkg::reg_idx_t   lookup_rs2,
	output ooo_pkg::operand_t   map_rs1,
	output ooo_pkg::operand_t   map_rs2,
	input  logic                rename_en,
	input  ooo_pkg::reg_idx_t   rename_rd,
	input  ooo_pkg::rob_tag_t   rename_tag,
	input  ooo_pkg::commit_t    commit
);
	import ooo_pkg::*;

	logic [num_arch_regs-1:0] map_valid;
	rob_tag_t map_tag [num_arch_regs];
	// tag of the retiring entry, tracks the rob head
	rob_tag_t commit_tag;

	// ready here means not renamed, read the register file
	assign map_rs1 = '{
		ready: (lookup_rs1 == '0) || !map_valid[lookup_rs1],
		tag:   map_tag[lookup_rs1],
		value: '0
	};
	assign map_rs2 = '{
		ready: (lookup_rs2 == '0) || !map_valid[lookup_rs2],
		tag:   map_tag[lookup_rs2],
		value: '0
	};

	always_ff @(posedge clock) begin
		if (reset) begin
			map_valid <= '0;
			commit_tag <= '0;
		end else begin
			// head starts at slot 0 and moves one per commit
			if (commit.valid)
				commit_tag <= commit_tag + rob_tag_t'(1);
			// drop the mapping once its producer retires
			if (commit.valid && map_valid[commit.rd] && map_tag[commit.rd] == commit_tag)
				map_valid[commit.rd] <= 1'b0;
			// a new rename of the same register wins
			if (rename_en) begin
				map_valid[rename_rd] <= 1'b1;
				map_tag[rename_rd] <= rename_tag;
			end
		end
	end

endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      alloc_en,
	input  ooo_pkg::reg_idx_t         alloc_rd,
	input  logic                      alloc_wr_en,
	input  logic                      alloc_done,
	input  logic [ooo_pkg::xlen-1:0]  alloc_pc,
	output ooo_pkg::rob_tag_t         alloc_tag,
	output logic                      rob_full,
	input  ooo_pkg::rob_tag_t         read_tag1,
	input  ooo_pkg::rob_tag_t         read_tag2,
	output ooo_pkg::operand_t         read_op1,
	output ooo_pkg::operand_t         read_op2,
	input  ooo_pkg::cdb_t             cdb,
	output ooo_pkg::commit_t          commit
);
	import ooo_pkg::*;

	rob_tag_t head;
	rob_tag_t tail;
	rob_tag_t cdb_offset;
	logic [$clog2(rob_depth):0] count;
	logic retire;

	// per-slot flags
	logic [rob_depth-1:0] done;
	logic [rob_depth-1:0] wr_en;
	// per-slot payload
	reg_idx_t rd [rob_depth];
	logic [xlen-1:0] data [rob_depth];
	logic [xlen-1:0] pc [rob_depth];

	assign rob_full = (count == rob_depth);
	assign alloc_tag = tail;

	//////////////////////////////////////////////////
	// operand read-out for issue
	//////////////////////////////////////////////////

	assign read_op1 = '{ready: done[read_tag1], tag: read_tag1, value: data[read_tag1]};
	assign read_op2 = '{ready: done[read_tag2], tag: read_tag2, value: data[read_tag2]};

	//////////////////////////////////////////////////
	// in-order commit from head
	//////////////////////////////////////////////////

	assign retire = (count != '0) && done[head];
	assign commit = '{
		valid: retire,
		wr_en: wr_en[head],
		rd:    rd[head],
		data:  data[head],
		pc:    pc[head]
	};

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
			wr_en <= '0;
		end else begin
			if (alloc_en) begin
				tail <= tail + rob_tag_t'(1);
				// non-alu words arrive already done
				done[tail] <= alloc_done;
				wr_en[tail] <= alloc_wr_en;
			end
			if (cdb.valid)
				done[cdb.tag] <= 1'b1;
			if (retire)
				head <= head + rob_tag_t'(1);
			count <= count + $bits(count)'(alloc_en) - $bits(count)'(retire);
		end
	end

	// payload, no reset
	always_ff @(posedge clock) begin
		if (alloc_en) begin
			rd[tail] <= alloc_rd;
			pc[tail] <= alloc_pc;
			data[tail] <= '0;
		end
		if (cdb.valid)
			data[cdb.tag] <= cdb.value;
	end

	// issue must stall on full
	assert property (@(posedge clock) disable iff (reset) alloc_en |-> !rob_full);

	// cdb tag must point into the occupied window
	assign cdb_offset = cdb.tag - head;
	assert property (@(posedge clock) disable iff (reset)
		cdb.valid |-> ({1'b0, cdb_offset} < count));

endmodule

/* hw/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
	input  logic                    clock,
	input  logic                    reset,
	input  ooo_pkg::issue_packet_t  issue,
	input  ooo_pkg::cdb_t           cdb,
	output logic                    rs_full,
	output ooo_pkg::issue_packet_t  exec
);
	import ooo_pkg::*;

	issue_packet_t slot [rs_depth];
	issue_packet_t incoming;
	logic [rs_depth-1:0] busy;
	logic [$clog2(rs_depth)-1:0] free_idx;
	logic [$clog2(rs_depth)-1:0] sel_idx;
	logic free_found;
	logic sel_found;

	// capture a broadcast result for a waiting operand
	function automatic operand_t wake(operand_t op, cdb_t bus);
		operand_t res;
		res = op;
		if (!op.ready && bus.valid && bus.tag == op.tag) begin
			res.ready = 1'b1;
			res.value = bus.value;
		end
		return res;
	endfunction

	//////////////////////////////////////////////////
	// free slot and dispatch select
	//////////////////////////////////////////////////

	always_comb begin
		free_found = 1'b0;
		free_idx = '0;
		sel_found = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < rs_depth; i++) begin
			busy[i] = slot[i].valid;
			if (!free_found && !slot[i].valid) begin
				free_found = 1'b1;
				free_idx = $bits(free_idx)'(i);
			end
			// lowest index with both operands in hand
			if (!sel_found && slot[i].valid && slot[i].src1.ready && slot[i].src2.ready) begin
				sel_found = 1'b1;
				sel_idx = $bits(sel_idx)'(i);
			end
		end
	end

	assign rs_full = &busy;

	always_comb begin
		exec = slot[sel_idx];
		exec.valid = sel_found;
	end

	// wakeup also covers the cycle the entry is written
	always_comb begin
		incoming = issue;
		incoming.src1 = wake(issue.src1, cdb);
		incoming.src2 = wake(issue.src2, cdb);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rs_depth; i++)
				slot[i].valid <= 1'b0;
		end else begin
			for (int i = 0; i < rs_depth; i++) begin
				if (slot[i].valid) begin
					slot[i].src1 <= wake(slot[i].src1, cdb);
					slot[i].src2 <= wake(slot[i].src2, cdb);
				end
			end
			// dispatched entry frees at the edge
			if (sel_found)
				slot[sel_idx].valid <= 1'b0;
			if (issue.valid)
				slot[free_idx] <= incoming;
		end
	end

	// issue holds off while every slot is busy
	assert property (@(posedge clock) disable iff (reset) issue.valid |-> !rs_full);

endmodule

/* ooo_core.f */
hw/ooo_pkg.sv
hw/fetch_unit.sv
hw/rename_map.sv
hw/reorder_buffer.sv
hw/issue_stage.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/ooo_core.sv
dv/ooo_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module ooo_core_tb -f ooo_core.f -Mdir build -o ooo_core_sim

./build/ooo_core_sim 2>&1 | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
	exit 0
fi
exit 1
